//--- source/uce_pkg.sv
package uce_pkg;

  // address and data sizes
  localparam int PADDR_W     = 32;
  localparam int DATA_W      = 64;
  localparam int BLOCK_W     = 128;
  localparam int BLOCK_OFF_W = 4;

  // cache geometry
  localparam int SETS    = 16;
  localparam int INDEX_W = 4;
  localparam int ASSOC   = 2;
  localparam int WAY_W   = 1;
  localparam int TAG_W   = PADDR_W - INDEX_W - BLOCK_OFF_W;

  // an uncached word is replicated this many times across a block
  localparam int WORDS_PER_BLOCK = BLOCK_W / DATA_W;

  // outstanding memory commands
  localparam int MAX_CREDITS = 4;
  localparam int CREDIT_W    = 3;

  typedef enum logic [1:0]
  {
    miss_load,
    uc_load,
    uc_store
  } req_type_e;

  typedef enum logic [1:0]
  {
    mem_rd,
    mem_uc_rd,
    mem_uc_wr
  } mem_msg_e;

  typedef enum logic
  {
    tag_clear,
    tag_set
  } tag_op_e;

  typedef enum logic
  {
    data_write,
    data_uncached
  } data_op_e;

  // selects which tag and data packets the fill writer forms
  typedef enum logic [1:0]
  {
    fill_clear,
    fill_block,
    fill_uncached
  } fill_mode_e;

endpackage

//--- source/uce_credit_counter.sv
`timescale 1ns/1ps

module uce_credit_counter
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_sent_i,
  input  logic resp_taken_i,
  output logic credits_full_o,
  output logic credits_empty_o
);

  logic [uce_pkg::CREDIT_W-1:0] count_r;

  assign credits_full_o  = (count_r == uce_pkg::CREDIT_W'(uce_pkg::MAX_CREDITS));
  assign credits_empty_o = (count_r == '0);

  // a command and a response in the same cycle leave the count unchanged
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
    end
    else if (cmd_sent_i && !resp_taken_i && !credits_full_o)
    begin
      count_r <= count_r + 1'b1;
    end
    else if (resp_taken_i && !cmd_sent_i && !credits_empty_o)
    begin
      count_r <= count_r - 1'b1;
    end
  end

endmodule

//--- source/uce_mem_cmd_gen.sv
`timescale 1ns/1ps

module uce_mem_cmd_gen
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                capture_i,
  input  logic                                cmd_direct_i,
  input  uce_pkg::req_type_e                  cache_req_type_i,
  input  logic [uce_pkg::PADDR_W-1:0]         cache_req_addr_i,
  input  logic [uce_pkg::DATA_W-1:0]          cache_req_data_i,
  input  logic [uce_pkg::WAY_W-1:0]           cache_req_way_i,
  output uce_pkg::req_type_e                  req_type_o,
  output uce_pkg::mem_msg_e                   mem_cmd_type_o,
  output logic [uce_pkg::PADDR_W-1:0]         mem_cmd_addr_o,
  output logic [uce_pkg::WAY_W-1:0]           mem_cmd_way_o,
  output logic [uce_pkg::DATA_W-1:0]          mem_cmd_data_o
);

  uce_pkg::req_type_e                 req_type_r;
  logic [uce_pkg::PADDR_W-1:0]        req_addr_r;
  logic [uce_pkg::DATA_W-1:0]         req_data_r;
  logic [uce_pkg::WAY_W-1:0]          req_way_r;

  uce_pkg::req_type_e                 sel_type;
  logic [uce_pkg::PADDR_W-1:0]        sel_addr;

  // the latched type picks the state that follows the command
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_type_r <= uce_pkg::miss_load;
    end
    else if (capture_i)
    begin
      req_type_r <= cache_req_type_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (capture_i)
    begin
      req_addr_r <= cache_req_addr_i;
      req_data_r <= cache_req_data_i;
      req_way_r  <= cache_req_way_i;
    end
  end

  assign req_type_o = req_type_r;

  // stores in ready go out straight from the request port
  assign sel_type       = cmd_direct_i ? cache_req_type_i : req_type_r;
  assign sel_addr       = cmd_direct_i ? cache_req_addr_i : req_addr_r;
  assign mem_cmd_way_o  = cmd_direct_i ? cache_req_way_i  : req_way_r;
  assign mem_cmd_data_o = cmd_direct_i ? cache_req_data_i : req_data_r;

  always_comb
  begin
    mem_cmd_type_o = uce_pkg::mem_uc_wr;
    mem_cmd_addr_o = sel_addr;
    case (sel_type)
      uce_pkg::miss_load:
      begin
        mem_cmd_type_o = uce_pkg::mem_rd;
        mem_cmd_addr_o = {sel_addr[uce_pkg::PADDR_W-1:uce_pkg::BLOCK_OFF_W],
                          {uce_pkg::BLOCK_OFF_W{1'b0}}};
      end
      uce_pkg::uc_load:
      begin
        mem_cmd_type_o = uce_pkg::mem_uc_rd;
      end
      default:
      begin
        mem_cmd_type_o = uce_pkg::mem_uc_wr;
      end
    endcase
  end

endmodule

//--- source/uce_fill_writer.sv
`timescale 1ns/1ps

module uce_fill_writer
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  uce_pkg::fill_mode_e                 fill_mode_i,
  input  logic                                clear_step_i,
  input  logic [uce_pkg::PADDR_W-1:0]         mem_resp_addr_i,
  input  logic [uce_pkg::WAY_W-1:0]           mem_resp_way_i,
  input  logic [uce_pkg::BLOCK_W-1:0]         mem_resp_data_i,
  output logic                                clear_last_o,
  output uce_pkg::tag_op_e                    tag_pkt_op_o,
  output logic [uce_pkg::INDEX_W-1:0]         tag_pkt_index_o,
  output logic [uce_pkg::WAY_W-1:0]           tag_pkt_way_o,
  output logic [uce_pkg::TAG_W-1:0]           tag_pkt_tag_o,
  output uce_pkg::data_op_e                   data_pkt_op_o,
  output logic [uce_pkg::INDEX_W-1:0]         data_pkt_index_o,
  output logic [uce_pkg::WAY_W-1:0]           data_pkt_way_o,
  output logic [uce_pkg::BLOCK_W-1:0]         data_pkt_data_o
);

  logic [uce_pkg::INDEX_W-1:0] clear_index_r;
  logic [uce_pkg::INDEX_W-1:0] resp_index;
  logic [uce_pkg::TAG_W-1:0]   resp_tag;
  logic                        clearing;

  // the index wraps back to zero after the last set
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      clear_index_r <= '0;
    end
    else if (clear_step_i)
    begin
      clear_index_r <= clear_index_r + 1'b1;
    end
  end

  assign clear_last_o = (clear_index_r == uce_pkg::INDEX_W'(uce_pkg::SETS - 1));

  assign resp_index = mem_resp_addr_i[uce_pkg::BLOCK_OFF_W +: uce_pkg::INDEX_W];
  assign resp_tag   = mem_resp_addr_i[uce_pkg::BLOCK_OFF_W + uce_pkg::INDEX_W +: uce_pkg::TAG_W];
  assign clearing   = (fill_mode_i == uce_pkg::fill_clear);

  // a clear invalidates every way of the set, so way and tag are don't care
  assign tag_pkt_op_o    = clearing ? uce_pkg::tag_clear : uce_pkg::tag_set;
  assign tag_pkt_index_o = clearing ? clear_index_r : resp_index;
  assign tag_pkt_way_o   = clearing ? '0 : mem_resp_way_i;
  assign tag_pkt_tag_o   = clearing ? '0 : resp_tag;

  assign data_pkt_index_o = resp_index;
  assign data_pkt_way_o   = mem_resp_way_i;

  always_comb
  begin
    if (fill_mode_i == uce_pkg::fill_uncached)
    begin
      data_pkt_op_o   = uce_pkg::data_uncached;
      data_pkt_data_o = {uce_pkg::WORDS_PER_BLOCK{mem_resp_data_i[uce_pkg::DATA_W-1:0]}};
    end
    else
    begin
      data_pkt_op_o   = uce_pkg::data_write;
      data_pkt_data_o = mem_resp_data_i;
    end
  end

endmodule

//--- source/uce_ctrl.sv
`timescale 1ns/1ps

module uce_ctrl
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 cache_req_v_i,
  input  uce_pkg::req_type_e   cache_req_type_i,
  input  uce_pkg::req_type_e   req_type_i,
  input  logic                 mem_cmd_yumi_i,
  input  logic                 mem_resp_v_i,
  input  uce_pkg::mem_msg_e    mem_resp_type_i,
  input  logic                 tag_pkt_yumi_i,
  input  logic                 data_pkt_yumi_i,
  input  logic                 clear_last_i,
  input  logic                 credits_full_i,
  output logic                 cache_req_yumi_o,
  output logic                 cache_req_busy_o,
  output logic                 cache_req_complete_o,
  output logic                 cache_req_critical_o,
  output logic                 cmd_direct_o,
  output logic                 mem_cmd_v_o,
  output logic                 mem_resp_yumi_o,
  output logic                 tag_pkt_v_o,
  output logic                 data_pkt_v_o,
  output uce_pkg::fill_mode_e  fill_mode_o,
  output logic                 clear_step_o
);

  typedef enum logic [2:0]
  {
    st_reset,
    st_clear,
    st_ready,
    st_send,
    st_fill,
    st_uc_wait
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   uc_store_v;
  logic   store_resp_v;
  logic   load_resp_v;
  logic   load_resp_yumi;

  assign uc_store_v   = cache_req_v_i && (cache_req_type_i == uce_pkg::uc_store);
  assign store_resp_v = mem_resp_v_i && (mem_resp_type_i == uce_pkg::mem_uc_wr);
  assign load_resp_v  = mem_resp_v_i && (mem_resp_type_i != uce_pkg::mem_uc_wr);

  // store responses carry nothing to write back and are taken at once
  assign mem_resp_yumi_o      = (store_resp_v && (state_r != st_reset)) || load_resp_yumi;
  assign cache_req_critical_o = load_resp_yumi;
  assign cache_req_busy_o     = (state_r == st_reset) || (state_r == st_clear) || credits_full_i;
  assign cmd_direct_o         = (state_r == st_ready);

  always_comb
  begin
    state_n              = state_r;
    cache_req_yumi_o     = 1'b0;
    cache_req_complete_o = 1'b0;
    mem_cmd_v_o          = 1'b0;
    load_resp_yumi       = 1'b0;
    tag_pkt_v_o          = 1'b0;
    data_pkt_v_o         = 1'b0;
    fill_mode_o          = uce_pkg::fill_block;
    clear_step_o         = 1'b0;
    case (state_r)
      st_reset:
      begin
        state_n = st_clear;
      end
      st_clear:
      begin
        tag_pkt_v_o          = 1'b1;
        fill_mode_o          = uce_pkg::fill_clear;
        clear_step_o         = tag_pkt_yumi_i;
        cache_req_complete_o = tag_pkt_yumi_i && clear_last_i;
        if (cache_req_complete_o)
        begin
          state_n = st_ready;
        end
      end
      st_ready:
      begin
        if (uc_store_v)
        begin
          mem_cmd_v_o          = !credits_full_i;
          cache_req_yumi_o     = mem_cmd_v_o && mem_cmd_yumi_i;
          cache_req_complete_o = cache_req_yumi_o;
        end
        else
        begin
          cache_req_yumi_o = cache_req_v_i;
          if (cache_req_v_i)
          begin
            state_n = st_send;
          end
        end
      end
      st_send:
      begin
        mem_cmd_v_o = !credits_full_i;
        if (mem_cmd_v_o && mem_cmd_yumi_i)
        begin
          state_n = (req_type_i == uce_pkg::miss_load) ? st_fill : st_uc_wait;
        end
      end
      st_fill:
      begin
        // tag and data are written together from one block response
        tag_pkt_v_o          = load_resp_v;
        data_pkt_v_o         = load_resp_v;
        load_resp_yumi       = load_resp_v && tag_pkt_yumi_i && data_pkt_yumi_i;
        cache_req_complete_o = load_resp_yumi;
        if (load_resp_yumi)
        begin
          state_n = st_ready;
        end
      end
      st_uc_wait:
      begin
        data_pkt_v_o         = load_resp_v;
        fill_mode_o          = uce_pkg::fill_uncached;
        load_resp_yumi       = load_resp_v && data_pkt_yumi_i;
        cache_req_complete_o = load_resp_yumi;
        if (load_resp_yumi)
        begin
          state_n = st_ready;
        end
      end
      default:
      begin
        state_n = st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= st_reset;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule

//--- source/uce_top.sv
`timescale 1ns/1ps

module uce_top
(
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                cache_req_v_i,
  input  uce_pkg::req_type_e                  cache_req_type_i,
  input  logic [uce_pkg::PADDR_W-1:0]         cache_req_addr_i,
  input  logic [uce_pkg::DATA_W-1:0]          cache_req_data_i,
  input  logic [uce_pkg::WAY_W-1:0]           cache_req_way_i,
  output logic                                cache_req_yumi_o,
  output logic                                cache_req_busy_o,
  output logic                                cache_req_complete_o,
  output logic                                cache_req_critical_o,
  output logic                                cache_req_credits_full_o,
  output logic                                cache_req_credits_empty_o,

  output logic                                tag_pkt_v_o,
  output uce_pkg::tag_op_e                    tag_pkt_op_o,
  output logic [uce_pkg::INDEX_W-1:0]         tag_pkt_index_o,
  output logic [uce_pkg::WAY_W-1:0]           tag_pkt_way_o,
  output logic [uce_pkg::TAG_W-1:0]           tag_pkt_tag_o,
  input  logic                                tag_pkt_yumi_i,

  output logic                                data_pkt_v_o,
  output uce_pkg::data_op_e                   data_pkt_op_o,
  output logic [uce_pkg::INDEX_W-1:0]         data_pkt_index_o,
  output logic [uce_pkg::WAY_W-1:0]           data_pkt_way_o,
  output logic [uce_pkg::BLOCK_W-1:0]         data_pkt_data_o,
  input  logic                                data_pkt_yumi_i,

  output logic                                mem_cmd_v_o,
  output uce_pkg::mem_msg_e                   mem_cmd_type_o,
  output logic [uce_pkg::PADDR_W-1:0]         mem_cmd_addr_o,
  output logic [uce_pkg::WAY_W-1:0]           mem_cmd_way_o,
  output logic [uce_pkg::DATA_W-1:0]          mem_cmd_data_o,
  input  logic                                mem_cmd_yumi_i,

  input  logic                                mem_resp_v_i,
  input  uce_pkg::mem_msg_e                   mem_resp_type_i,
  input  logic [uce_pkg::PADDR_W-1:0]         mem_resp_addr_i,
  input  logic [uce_pkg::WAY_W-1:0]           mem_resp_way_i,
  input  logic [uce_pkg::BLOCK_W-1:0]         mem_resp_data_i,
  output logic                                mem_resp_yumi_o
);

  uce_pkg::req_type_e  req_type;
  uce_pkg::fill_mode_e fill_mode;
  logic                cmd_direct;
  logic                clear_step;
  logic                clear_last;

  uce_ctrl u_uce_ctrl
  (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .cache_req_v_i        (cache_req_v_i),
    .cache_req_type_i     (cache_req_type_i),
    .req_type_i           (req_type),
    .mem_cmd_yumi_i       (mem_cmd_yumi_i),
    .mem_resp_v_i         (mem_resp_v_i),
    .mem_resp_type_i      (mem_resp_type_i),
    .tag_pkt_yumi_i       (tag_pkt_yumi_i),
    .data_pkt_yumi_i      (data_pkt_yumi_i),
    .clear_last_i         (clear_last),
    .credits_full_i       (cache_req_credits_full_o),
    .cache_req_yumi_o     (cache_req_yumi_o),
    .cache_req_busy_o     (cache_req_busy_o),
    .cache_req_complete_o (cache_req_complete_o),
    .cache_req_critical_o (cache_req_critical_o),
    .cmd_direct_o         (cmd_direct),
    .mem_cmd_v_o          (mem_cmd_v_o),
    .mem_resp_yumi_o      (mem_resp_yumi_o),
    .tag_pkt_v_o          (tag_pkt_v_o),
    .data_pkt_v_o         (data_pkt_v_o),
    .fill_mode_o          (fill_mode),
    .clear_step_o         (clear_step)
  );

  uce_mem_cmd_gen u_uce_mem_cmd_gen
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .capture_i        (cache_req_yumi_o),
    .cmd_direct_i     (cmd_direct),
    .cache_req_type_i (cache_req_type_i),
    .cache_req_addr_i (cache_req_addr_i),
    .cache_req_data_i (cache_req_data_i),
    .cache_req_way_i  (cache_req_way_i),
    .req_type_o       (req_type),
    .mem_cmd_type_o   (mem_cmd_type_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_way_o    (mem_cmd_way_o),
    .mem_cmd_data_o   (mem_cmd_data_o)
  );

  uce_fill_writer u_uce_fill_writer
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fill_mode_i      (fill_mode),
    .clear_step_i     (clear_step),
    .mem_resp_addr_i  (mem_resp_addr_i),
    .mem_resp_way_i   (mem_resp_way_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .clear_last_o     (clear_last),
    .tag_pkt_op_o     (tag_pkt_op_o),
    .tag_pkt_index_o  (tag_pkt_index_o),
    .tag_pkt_way_o    (tag_pkt_way_o),
    .tag_pkt_tag_o    (tag_pkt_tag_o),
    .data_pkt_op_o    (data_pkt_op_o),
    .data_pkt_index_o (data_pkt_index_o),
    .data_pkt_way_o   (data_pkt_way_o),
    .data_pkt_data_o  (data_pkt_data_o)
  );

  uce_credit_counter u_uce_credit_counter
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_sent_i      (mem_cmd_v_o & mem_cmd_yumi_i),
    .resp_taken_i    (mem_resp_yumi_o),
    .credits_full_o  (cache_req_credits_full_o),
    .credits_empty_o (cache_req_credits_empty_o)
  );

endmodule

//--- verification/uce_tb.sv
`timescale 1ns/1ps

module uce_tb;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RANDOM_REQS    = 30;

  logic                              clk = 1'b0;
  logic                              reset;
  logic                              cache_req_v;
  uce_pkg::req_type_e                cache_req_type;
  logic [uce_pkg::PADDR_W-1:0]       cache_req_addr;
  logic [uce_pkg::DATA_W-1:0]        cache_req_data;
  logic [uce_pkg::WAY_W-1:0]         cache_req_way;
  logic                              cache_req_yumi;
  logic                              cache_req_busy;
  logic                              cache_req_complete;
  logic                              cache_req_critical;
  logic                              credits_full;
  logic                              credits_empty;
  logic                              tag_pkt_v;
  uce_pkg::tag_op_e                  tag_pkt_op;
  logic [uce_pkg::INDEX_W-1:0]       tag_pkt_index;
  logic [uce_pkg::WAY_W-1:0]         tag_pkt_way;
  logic [uce_pkg::TAG_W-1:0]         tag_pkt_tag;
  logic                              data_pkt_v;
  uce_pkg::data_op_e                 data_pkt_op;
  logic [uce_pkg::INDEX_W-1:0]       data_pkt_index;
  logic [uce_pkg::WAY_W-1:0]         data_pkt_way;
  logic [uce_pkg::BLOCK_W-1:0]       data_pkt_data;
  logic                              pkt_yumi;
  logic                              mem_cmd_v;
  uce_pkg::mem_msg_e                 mem_cmd_type;
  logic [uce_pkg::PADDR_W-1:0]       mem_cmd_addr;
  logic [uce_pkg::WAY_W-1:0]         mem_cmd_way;
  logic [uce_pkg::DATA_W-1:0]        mem_cmd_data;
  logic                              mem_cmd_yumi;
  logic                              mem_resp_v;
  uce_pkg::mem_msg_e                 mem_resp_type;
  logic [uce_pkg::PADDR_W-1:0]       mem_resp_addr;
  logic [uce_pkg::WAY_W-1:0]         mem_resp_way;
  logic [uce_pkg::BLOCK_W-1:0]       mem_resp_data;
  logic                              mem_resp_yumi;

  integer seed;
  int     cycle_count;
  logic   hold_resp;
  logic   resp_taken;
  logic   prev_load_yumi;
  logic   tag_hs;
  logic   data_hs;
  logic   cmd_hs;
  logic   clear_done;
  logic [98:0]  cmd_seen;
  logic [29:0]  tag_seen;
  logic [133:0] data_seen;

  // expected commands and packets, oldest first
  logic [98:0]  exp_cmd_q[$];
  logic [29:0]  exp_tag_q[$];
  logic [133:0] exp_data_q[$];

  // responses owed by the memory model
  uce_pkg::mem_msg_e           rq_type[$];
  logic [uce_pkg::PADDR_W-1:0] rq_addr[$];
  logic [uce_pkg::WAY_W-1:0]   rq_way[$];
  logic [uce_pkg::BLOCK_W-1:0] rq_data[$];

  uce_top u_uce_top
  (
    .clk_i                     (clk),
    .reset_i                   (reset),
    .cache_req_v_i             (cache_req_v),
    .cache_req_type_i          (cache_req_type),
    .cache_req_addr_i          (cache_req_addr),
    .cache_req_data_i          (cache_req_data),
    .cache_req_way_i           (cache_req_way),
    .cache_req_yumi_o          (cache_req_yumi),
    .cache_req_busy_o          (cache_req_busy),
    .cache_req_complete_o      (cache_req_complete),
    .cache_req_critical_o      (cache_req_critical),
    .cache_req_credits_full_o  (credits_full),
    .cache_req_credits_empty_o (credits_empty),
    .tag_pkt_v_o               (tag_pkt_v),
    .tag_pkt_op_o              (tag_pkt_op),
    .tag_pkt_index_o           (tag_pkt_index),
    .tag_pkt_way_o             (tag_pkt_way),
    .tag_pkt_tag_o             (tag_pkt_tag),
    .tag_pkt_yumi_i            (pkt_yumi),
    .data_pkt_v_o              (data_pkt_v),
    .data_pkt_op_o             (data_pkt_op),
    .data_pkt_index_o          (data_pkt_index),
    .data_pkt_way_o            (data_pkt_way),
    .data_pkt_data_o           (data_pkt_data),
    .data_pkt_yumi_i           (pkt_yumi),
    .mem_cmd_v_o               (mem_cmd_v),
    .mem_cmd_type_o            (mem_cmd_type),
    .mem_cmd_addr_o            (mem_cmd_addr),
    .mem_cmd_way_o             (mem_cmd_way),
    .mem_cmd_data_o            (mem_cmd_data),
    .mem_cmd_yumi_i            (mem_cmd_yumi),
    .mem_resp_v_i              (mem_resp_v),
    .mem_resp_type_i           (mem_resp_type),
    .mem_resp_addr_i           (mem_resp_addr),
    .mem_resp_way_i            (mem_resp_way),
    .mem_resp_data_i           (mem_resp_data),
    .mem_resp_yumi_o           (mem_resp_yumi)
  );

  // contents of backing memory, a fixed mix of the block address
  function automatic logic [uce_pkg::BLOCK_W-1:0] mem_block(input logic [31:0] addr);
    logic [27:0] blk;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    blk = addr[31:4];
    w0 = {blk, 4'h5} ^ 32'h5a5a_a5a5;
    w1 = {blk[13:0], blk[27:14], 4'hc};
    w2 = ~{4'h9, blk};
    w3 = {blk, 4'h0} + 32'h1357_2468;
    mem_block = {w3, w2, w1, w0};
  endfunction

  task automatic check_value(input logic [159:0] actual, input logic [159:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  // way and data are only meaningful where the request kind uses them
  task automatic queue_expected(input uce_pkg::req_type_e kind, input logic [31:0] addr,
                                input logic [63:0] data, input logic way);
    logic [127:0] blk;
    blk = mem_block(addr);
    case (kind)
      uce_pkg::uc_store:
      begin
        exp_cmd_q.push_back({uce_pkg::mem_uc_wr, addr, 1'b0, data});
      end
      uce_pkg::uc_load:
      begin
        exp_cmd_q.push_back({uce_pkg::mem_uc_rd, addr, 1'b0, 64'h0});
        exp_data_q.push_back({uce_pkg::data_uncached, 4'h0, 1'b0, {2{blk[63:0]}}});
      end
      default:
      begin
        exp_cmd_q.push_back({uce_pkg::mem_rd, addr[31:4], 4'h0, way, 64'h0});
        exp_tag_q.push_back({uce_pkg::tag_set, addr[7:4], way, addr[31:8]});
        exp_data_q.push_back({uce_pkg::data_write, addr[7:4], way, blk});
      end
    endcase
  endtask

  task automatic send_req(input uce_pkg::req_type_e kind, input logic [31:0] addr,
                          input logic [63:0] data, input logic way);
    @(negedge clk);
    while (cache_req_busy)
      @(negedge clk);
    @(posedge clk);
    #1;
    queue_expected(kind, addr, data, way);
    cache_req_v    = 1'b1;
    cache_req_type = kind;
    cache_req_addr = addr;
    cache_req_data = data;
    cache_req_way  = way;
    @(negedge clk);
    while (!cache_req_yumi)
      @(negedge clk);
    @(posedge clk);
    #1;
    cache_req_v = 1'b0;
  endtask

  // idle means nothing expected and no response left in the memory model
  task automatic wait_idle();
    @(posedge clk);
    #2;
    while (exp_cmd_q.size() != 0 || exp_tag_q.size() != 0 || exp_data_q.size() != 0 ||
           rq_addr.size() != 0 || mem_resp_v)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    forever
      #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the engine stopped making progress", cycle_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // memory side: random stalls, responses in command order after a random wait
  always @(posedge clk)
  begin
    #1;
    mem_cmd_yumi = ($random(seed) & 3) != 0;
    // the tag and data memories accept a fill together
    pkt_yumi = ($random(seed) & 3) != 0;
    if (resp_taken)
    begin
      mem_resp_v = 1'b0;
      resp_taken = 1'b0;
    end
    if (!mem_resp_v && rq_addr.size() != 0 && !hold_resp && (($random(seed) & 1) != 0))
    begin
      mem_resp_v    = 1'b1;
      mem_resp_type = rq_type[0];
      mem_resp_addr = rq_addr[0];
      mem_resp_way  = rq_way[0];
      mem_resp_data = rq_data[0];
    end
  end

  // compares every handshake against the expected queues in mid cycle
  always @(negedge clk)
  begin
    if (reset)
    begin
      check_value({tag_pkt_v, data_pkt_v, mem_cmd_v, cache_req_yumi, mem_resp_yumi,
                   cache_req_complete, cache_req_critical}, '0, "handshake output in reset");
      prev_load_yumi = 1'b0;
    end
    else
    begin
      tag_hs     = tag_pkt_v && pkt_yumi;
      data_hs    = data_pkt_v && pkt_yumi;
      cmd_hs     = mem_cmd_v && mem_cmd_yumi;
      clear_done = tag_hs && (tag_pkt_op == uce_pkg::tag_clear) &&
                   (tag_pkt_index == uce_pkg::SETS - 1);
      if (tag_pkt_v && tag_pkt_op == uce_pkg::tag_clear)
        check_value(cache_req_busy, 1'b1, "busy during clear");
      check_value(cache_req_complete,
                  data_hs || (cmd_hs && mem_cmd_type == uce_pkg::mem_uc_wr) || clear_done,
                  "request completion");
      check_value(cache_req_critical, data_hs, "critical data pulse");
      check_value(mem_resp_yumi,
                  mem_resp_v && (mem_resp_type == uce_pkg::mem_uc_wr || data_hs),
                  "response acknowledge");
      if (prev_load_yumi && !credits_full)
        check_value(mem_cmd_v, 1'b1, "load command one cycle after acceptance");
      prev_load_yumi = cache_req_yumi && (cache_req_type != uce_pkg::uc_store);

      if (cmd_hs)
      begin
        if (exp_cmd_q.size() == 0)
          abort_run("a memory command was sent that no request asked for");
        cmd_seen = {mem_cmd_type, mem_cmd_addr,
                    (mem_cmd_type == uce_pkg::mem_rd) ? mem_cmd_way : 1'b0,
                    (mem_cmd_type == uce_pkg::mem_uc_wr) ? mem_cmd_data : 64'h0};
        check_value(cmd_seen, exp_cmd_q.pop_front(), "memory command");
        rq_type.push_back(mem_cmd_type);
        rq_addr.push_back(mem_cmd_addr);
        rq_way.push_back(mem_cmd_way);
        rq_data.push_back((mem_cmd_type == uce_pkg::mem_uc_wr) ? '0 : mem_block(mem_cmd_addr));
      end

      if (tag_hs)
      begin
        if (exp_tag_q.size() == 0)
          abort_run("a tag packet was written that no request asked for");
        if (tag_pkt_op == uce_pkg::tag_clear)
          tag_seen = {tag_pkt_op, tag_pkt_index, 25'h0};
        else
          tag_seen = {tag_pkt_op, tag_pkt_index, tag_pkt_way, tag_pkt_tag};
        check_value(tag_seen, exp_tag_q.pop_front(), "tag packet");
      end

      if (data_hs)
      begin
        if (exp_data_q.size() == 0)
          abort_run("a data packet was written that no request asked for");
        if (data_pkt_op == uce_pkg::data_uncached)
          data_seen = {data_pkt_op, 5'h0, data_pkt_data};
        else
          data_seen = {data_pkt_op, data_pkt_index, data_pkt_way, data_pkt_data};
        check_value(data_seen, exp_data_q.pop_front(), "data packet");
      end

      if (mem_resp_v && mem_resp_yumi)
      begin
        void'(rq_type.pop_front());
        void'(rq_addr.pop_front());
        void'(rq_way.pop_front());
        void'(rq_data.pop_front());
        resp_taken = 1'b1;
      end
    end
  end

  initial
  begin
    uce_pkg::req_type_e kind;
    logic [31:0]        rnd;
    logic [63:0]        data;
    seed           = 32'h12dd_b75b;
    cycle_count    = 0;
    reset          = 1'b1;
    cache_req_v    = 1'b0;
    cache_req_type = uce_pkg::uc_store;
    cache_req_addr = '0;
    cache_req_data = '0;
    cache_req_way  = '0;
    pkt_yumi       = 1'b0;
    mem_cmd_yumi   = 1'b0;
    mem_resp_v     = 1'b0;
    mem_resp_type  = uce_pkg::mem_rd;
    mem_resp_addr  = '0;
    mem_resp_way   = '0;
    mem_resp_data  = '0;
    hold_resp      = 1'b0;
    resp_taken     = 1'b0;
    prev_load_yumi = 1'b0;
    for (int i = 0; i < uce_pkg::SETS; i++)
      exp_tag_q.push_back({uce_pkg::tag_clear, i[3:0], 25'h0});
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // every set is cleared in order before requests are taken
    wait_idle();
    check_value(cache_req_busy, 1'b0, "busy after clear");

    send_req(uce_pkg::uc_store, 32'h0000_1238, 64'h0123_4567_89ab_cdef, 1'b0);
    send_req(uce_pkg::uc_load, 32'h0000_2a4c, 64'h0, 1'b1);
    send_req(uce_pkg::miss_load, 32'hcafe_1574, 64'h0, 1'b1);
    send_req(uce_pkg::miss_load, 32'h8000_00f0, 64'h0, 1'b0);
    wait_idle();

    // with responses held back the fifth store must wait
    hold_resp = 1'b1;
    for (int i = 0; i < uce_pkg::MAX_CREDITS; i++)
      send_req(uce_pkg::uc_store, 32'h0000_4000 + 32'(i * 8), 64'h1111_0000 + 64'(i), 1'b0);
    @(negedge clk);
    check_value(credits_full, 1'b1, "credits full after four stores");
    check_value(cache_req_busy, 1'b1, "busy while credits are full");
    @(posedge clk);
    #1;
    cache_req_v    = 1'b1;
    cache_req_type = uce_pkg::uc_store;
    cache_req_addr = 32'h0000_5000;
    repeat (6)
    begin
      @(negedge clk);
      check_value({mem_cmd_v, cache_req_yumi}, 2'b00, "store accepted while credits full");
    end
    @(posedge clk);
    #1;
    cache_req_v = 1'b0;
    #1;
    hold_resp = 1'b0;
    wait_idle();
    check_value(credits_empty, 1'b1, "credits empty after all responses");

    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      @(negedge clk);
      kind = uce_pkg::req_type_e'($unsigned($random(seed)) % 3);
      rnd  = $random(seed);
      data = {$random(seed), $random(seed)};
      send_req(kind, rnd, data, data[7]);
    end
    wait_idle();
    check_value(credits_empty, 1'b1, "credits empty at the end");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- project.f
source/uce_pkg.sv
source/uce_credit_counter.sv
source/uce_mem_cmd_gen.sv
source/uce_fill_writer.sv
source/uce_ctrl.sv
source/uce_top.sv
verification/uce_tb.sv
